// ==== hdl/core_pkg.sv ====
package core_pkg;

    // ------------------------------------------------------------------------
    // Data width and base encodings
    // ------------------------------------------------------------------------
    localparam int XLEN = 32;

    // Major opcodes handled by the execute core
    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011
    } opcode_e;

    // ALU funct3 values, shared by OP_IMM and OP_REG
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // Branch conditions, 010 and 011 are unused
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // ------------------------------------------------------------------------
    // Instruction formats, all 32 bits, MSB first
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // One word, six views; the opcode picks which one is meaningful
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } instr_t;

    // ------------------------------------------------------------------------
    // Stage records
    // ------------------------------------------------------------------------
    // Decode-to-execute record
    typedef struct packed {
        logic            valid;
        logic            illegal;
        opcode_e         opcode;
        logic [2:0]      funct3;
        logic            alt;
        logic            write_enable;
        logic [4:0]      write_index;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] rs1_value;
        logic [XLEN-1:0] rs2_value;
        logic [XLEN-1:0] immediate;
    } exec_rec_t;

    typedef struct packed {
        logic [XLEN-1:0] alu_result;
    } alu_out_t;

    typedef struct packed {
        logic            is_jump;
        logic            taken;
        logic [XLEN-1:0] target;
        logic [XLEN-1:0] link;
    } jb_out_t;

    // Registered result of the execute core
    typedef struct packed {
        logic            valid;
        logic            illegal;
        logic            write_enable;
        logic [4:0]      write_index;
        logic [XLEN-1:0] write_data;
        logic            redirect;
        logic [XLEN-1:0] redirect_address;
    } wb_rec_t;

endpackage

// ==== hdl/instruction_decoder.sv ====
module instruction_decoder
(
    input  logic                      CLK,
    input  logic                      reset,
    input  logic                      in_valid,
    input  core_pkg::instr_t          instruction,
    input  logic [core_pkg::XLEN-1:0] pc,
    input  logic [core_pkg::XLEN-1:0] rs1_value,
    input  logic [core_pkg::XLEN-1:0] rs2_value,
    output core_pkg::exec_rec_t       exec
);

    core_pkg::opcode_e         opcode;
    logic                      legal;
    logic                      writes;
    logic                      alt;
    logic [core_pkg::XLEN-1:0] immediate;
    core_pkg::exec_rec_t       exec_next;

    // ------------------------------------------------------------------------
    // Format decode and immediate generation
    // ------------------------------------------------------------------------
    always_comb
    begin
        opcode    = core_pkg::opcode_e'(instruction.r.opcode);
        legal     = 1'b1;
        writes    = 1'b0;
        alt       = 1'b0;
        immediate = '0;
        case (opcode)
            // Upper immediate, low 12 bits zero
            core_pkg::OP_LUI, core_pkg::OP_AUIPC:
            begin
                immediate = {instruction.u.imm_31_12, 12'b0};
                writes    = 1'b1;
            end
            core_pkg::OP_JAL:
            begin
                immediate = {{12{instruction.j.imm_20}}, instruction.j.imm_19_12,
                             instruction.j.imm_11, instruction.j.imm_10_1, 1'b0};
                writes    = 1'b1;
            end
            // JALR only defines funct3 000
            core_pkg::OP_JALR:
            begin
                immediate = {{20{instruction.i.imm_11_0[11]}}, instruction.i.imm_11_0};
                writes    = 1'b1;
                legal     = (instruction.i.funct3 == core_pkg::F3_ADD);
            end
            core_pkg::OP_BRANCH:
            begin
                immediate = {{20{instruction.b.imm_12}}, instruction.b.imm_11,
                             instruction.b.imm_10_5, instruction.b.imm_4_1, 1'b0};
                legal     = !(instruction.b.funct3 inside {3'b010, 3'b011});
            end
            core_pkg::OP_IMM:
            begin
                immediate = {{20{instruction.i.imm_11_0[11]}}, instruction.i.imm_11_0};
                writes    = 1'b1;
                // Shift-immediates reuse imm[11:5] as funct7
                if (instruction.i.funct3 == core_pkg::F3_SLL)
                    legal = (instruction.i.imm_11_0[11:5] == 7'b0);
                else if (instruction.i.funct3 == core_pkg::F3_SR)
                begin
                    legal = instruction.i.imm_11_0[11:5] inside {7'b0000000, 7'b0100000};
                    alt   = instruction.i.imm_11_0[10];
                end
            end
            core_pkg::OP_REG:
            begin
                writes = 1'b1;
                alt    = instruction.r.funct7[5];
                legal  = instruction.r.funct7 inside {7'b0000000, 7'b0100000};
                // Alternate encoding only exists for SUB and SRA
                if (instruction.r.funct7[5])
                    legal = legal &&
                            (instruction.r.funct3 inside {core_pkg::F3_ADD, core_pkg::F3_SR});
            end
            default:
            begin
                // Store layout for everything else, carried but never acted on
                immediate = {{20{instruction.s.imm_11_5[6]}}, instruction.s.imm_11_5,
                             instruction.s.imm_4_0};
                legal     = 1'b0;
            end
        endcase
    end

    // ------------------------------------------------------------------------
    // Record assembly
    // ------------------------------------------------------------------------
    always_comb
    begin
        exec_next.valid        = in_valid;
        exec_next.illegal      = in_valid && !legal;
        exec_next.opcode       = opcode;
        exec_next.funct3       = instruction.r.funct3;
        exec_next.alt          = alt;
        // Branches and unknown words never write
        exec_next.write_enable = in_valid && legal && writes;
        exec_next.write_index  = instruction.r.rd;
        exec_next.pc           = pc;
        exec_next.rs1_value    = rs1_value;
        exec_next.rs2_value    = rs2_value;
        exec_next.immediate    = immediate;
    end

    // Decode-to-execute register, control bits cleared on reset
    always_ff @(posedge CLK)
    begin
        exec <= exec_next;
        if (reset)
        begin
            exec.valid        <= 1'b0;
            exec.illegal      <= 1'b0;
            exec.write_enable <= 1'b0;
        end
    end

endmodule

// ==== hdl/arithmetic_logic_unit.sv ====
module arithmetic_logic_unit
(
    input  core_pkg::exec_rec_t exec,
    output core_pkg::alu_out_t  alu
);

    logic [core_pkg::XLEN-1:0] operand_a;
    logic [core_pkg::XLEN-1:0] operand_b;
    logic [4:0]                shamt;
    logic [core_pkg::XLEN-1:0] result;

    // ------------------------------------------------------------------------
    // Operand selection
    // ------------------------------------------------------------------------
    assign operand_a = exec.rs1_value;

    // Register form takes rs2, everything else the immediate
    assign operand_b = (exec.opcode == core_pkg::OP_REG) ? exec.rs2_value : exec.immediate;

    // Shift amount is the low five bits in both forms
    assign shamt = operand_b[4:0];

    // ------------------------------------------------------------------------
    // Function select
    // ------------------------------------------------------------------------
    always_comb
    begin
        result = '0;
        case (exec.opcode)
            core_pkg::OP_LUI:
                result = exec.immediate;
            // PC-relative upper immediate
            core_pkg::OP_AUIPC:
                result = exec.pc + exec.immediate;
            core_pkg::OP_IMM, core_pkg::OP_REG:
            begin
                case (exec.funct3)
                    // alt is only set for SUB, never for ADDI
                    core_pkg::F3_ADD:
                        result = exec.alt ? operand_a - operand_b : operand_a + operand_b;
                    core_pkg::F3_SLL:
                        result = operand_a << shamt;
                    core_pkg::F3_SLT:
                        result = {31'b0, $signed(operand_a) < $signed(operand_b)};
                    core_pkg::F3_SLTU:
                        result = {31'b0, operand_a < operand_b};
                    core_pkg::F3_XOR:
                        result = operand_a ^ operand_b;
                    // Arithmetic or logical right shift
                    core_pkg::F3_SR:
                        result = exec.alt ? core_pkg::XLEN'($signed(operand_a) >>> shamt)
                                          : operand_a >> shamt;
                    core_pkg::F3_OR:
                        result = operand_a | operand_b;
                    core_pkg::F3_AND:
                        result = operand_a & operand_b;
                endcase
            end
            // Jumps and branches take no ALU result
            default:
                result = '0;
        endcase
    end

    assign alu.alu_result = result;

endmodule

// ==== hdl/jump_branch_unit.sv ====
module jump_branch_unit
(
    input  core_pkg::exec_rec_t exec,
    output core_pkg::jb_out_t   jb
);

    logic                      equal;
    logic                      less_signed;
    logic                      less_unsigned;
    logic                      condition;
    logic [core_pkg::XLEN-1:0] jalr_sum;

    // ------------------------------------------------------------------------
    // Operand comparison
    // ------------------------------------------------------------------------
    assign equal         = (exec.rs1_value == exec.rs2_value);
    assign less_signed   = ($signed(exec.rs1_value) < $signed(exec.rs2_value));
    assign less_unsigned = (exec.rs1_value < exec.rs2_value);

    // Condition per branch funct3
    always_comb
    begin
        case (exec.funct3)
            core_pkg::F3_BEQ:  condition = equal;
            core_pkg::F3_BNE:  condition = !equal;
            core_pkg::F3_BLT:  condition = less_signed;
            core_pkg::F3_BGE:  condition = !less_signed;
            core_pkg::F3_BLTU: condition = less_unsigned;
            core_pkg::F3_BGEU: condition = !less_unsigned;
            // Reserved encodings never branch
            default:           condition = 1'b0;
        endcase
    end

    // ------------------------------------------------------------------------
    // Control outputs
    // ------------------------------------------------------------------------
    assign jb.is_jump = (exec.opcode == core_pkg::OP_JAL) || (exec.opcode == core_pkg::OP_JALR);
    assign jb.taken   = (exec.opcode == core_pkg::OP_BRANCH) && condition;

    // Register-relative jump target
    assign jalr_sum = exec.rs1_value + exec.immediate;

    // JALR clears bit 0, others are PC-relative
    assign jb.target = (exec.opcode == core_pkg::OP_JALR)
                     ? {jalr_sum[core_pkg::XLEN-1:1], 1'b0}
                     : exec.pc + exec.immediate;

    // Return address for JAL and JALR
    assign jb.link = exec.pc + core_pkg::XLEN'(4);

endmodule

// ==== hdl/writeback_select.sv ====
module writeback_select
(
    input  logic                CLK,
    input  logic                reset,
    input  core_pkg::exec_rec_t exec,
    input  core_pkg::alu_out_t  alu,
    input  core_pkg::jb_out_t   jb,
    output core_pkg::wb_rec_t   wb
);

    core_pkg::wb_rec_t wb_next;
    logic              active;

    // Valid, decoded instruction in execute
    assign active = exec.valid && !exec.illegal;

    // ------------------------------------------------------------------------
    // Result selection
    // ------------------------------------------------------------------------
    always_comb
    begin
        wb_next.valid            = exec.valid;
        wb_next.illegal          = exec.illegal;
        wb_next.write_index      = exec.write_index;
        // x0 is hardwired to zero, so no write ever reaches it
        wb_next.write_enable     = exec.write_enable && (exec.write_index != 5'd0);
        // Link address for jumps, ALU for the rest
        wb_next.write_data       = jb.is_jump ? jb.link : alu.alu_result;
        wb_next.redirect         = active && (jb.taken || jb.is_jump);
        wb_next.redirect_address = jb.target;
    end

    // ------------------------------------------------------------------------
    // Write-back register
    // ------------------------------------------------------------------------
    always_ff @(posedge CLK)
    begin
        wb <= wb_next;
        if (reset)
        begin
            wb.valid        <= 1'b0;
            wb.illegal      <= 1'b0;
            wb.write_enable <= 1'b0;
            wb.redirect     <= 1'b0;
        end
    end

endmodule

// ==== hdl/execute_core.sv ====
module execute_core
(
    input  logic                      CLK,
    input  logic                      reset,
    input  logic                      in_valid,
    input  core_pkg::instr_t          instruction,
    input  logic [core_pkg::XLEN-1:0] pc,
    input  logic [core_pkg::XLEN-1:0] rs1_value,
    input  logic [core_pkg::XLEN-1:0] rs2_value,
    output core_pkg::wb_rec_t         wb
);

    // Decode-to-execute record and the two unit results
    core_pkg::exec_rec_t exec;
    core_pkg::alu_out_t  alu;
    core_pkg::jb_out_t   jb;

    // ------------------------------------------------------------------------
    // Decode stage, registered at the first edge
    // ------------------------------------------------------------------------
    instruction_decoder i_decoder
    (
        .CLK         (CLK),
        .reset       (reset),
        .in_valid    (in_valid),
        .instruction (instruction),
        .pc          (pc),
        .rs1_value   (rs1_value),
        .rs2_value   (rs2_value),
        .exec        (exec)
    );

    // ------------------------------------------------------------------------
    // Execute stage, both units in parallel
    // ------------------------------------------------------------------------
    arithmetic_logic_unit i_alu
    (
        .exec (exec),
        .alu  (alu)
    );

    jump_branch_unit i_jbu
    (
        .exec (exec),
        .jb   (jb)
    );

    // Merged result, registered at the second edge
    writeback_select i_wb_select
    (
        .CLK   (CLK),
        .reset (reset),
        .exec  (exec),
        .alu   (alu),
        .jb    (jb),
        .wb    (wb)
    );

endmodule

// ==== dv/execute_core_assertions.sv ====
module execute_core_assertions
(
    input logic              CLK,
    input logic              reset,
    input logic              in_valid,
    input core_pkg::wb_rec_t wb
);

    timeunit 1ns;
    timeprecision 1ps;

    // Failed assertions, read by the testbench at the end
    int unsigned fail_count = 0;

    // ------------------------------------------------------------------------
    // Output record invariants
    // ------------------------------------------------------------------------
    // Output record cleared by reset
    reset_clears_valid: assert property (@(posedge CLK) reset |=> !wb.valid)
    else
    begin
        $error("wb.valid set in the cycle after reset");
        fail_count++;
    end

    // Writes and redirects only from valid records
    effects_need_valid: assert property (@(posedge CLK) disable iff (reset)
                                         (wb.write_enable || wb.redirect) |-> wb.valid)
    else
    begin
        $error("write or redirect without wb.valid");
        fail_count++;
    end

    no_x0_write: assert property (@(posedge CLK) disable iff (reset)
                                  wb.write_enable |-> (wb.write_index != 5'd0))
    else
    begin
        $error("write enabled for x0");
        fail_count++;
    end

    // Fixed two-cycle latency
    two_cycle_latency: assert property (@(posedge CLK) disable iff (reset)
                                        in_valid |-> ##2 wb.valid)
    else
    begin
        $error("valid input not seen on wb two cycles later");
        fail_count++;
    end

endmodule

bind execute_core execute_core_assertions i_checks
(
    .CLK      (CLK),
    .reset    (reset),
    .in_valid (in_valid),
    .wb       (wb)
);

// ==== dv/execute_core_tb.sv ====
module execute_core_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_INSTR   = 3000;
    localparam int DRAIN_LIMIT = 20;

    logic                  CLK;
    logic                  reset;
    logic                  in_valid;
    core_pkg::instr_t      instruction;
    logic [31:0]           pc;
    logic [31:0]           rs1_value;
    logic [31:0]           rs2_value;
    core_pkg::wb_rec_t     wb;

    // Expected records, the cycle each one is due and its test name
    core_pkg::wb_rec_t     expected_q[$];
    int                    due_q[$];
    string                 name_q[$];

    int                    cycle;
    int                    waited;
    int                    check_count;
    int                    error_count;
    int                    timeout_count;

    execute_core i_dut
    (
        .CLK         (CLK),
        .reset       (reset),
        .in_valid    (in_valid),
        .instruction (instruction),
        .pc          (pc),
        .rs1_value   (rs1_value),
        .rs2_value   (rs2_value),
        .wb          (wb)
    );

    always #5 CLK = !CLK;

    // ------------------------------------------------------------------------
    // Reference model, straight from the RV32I rules
    // ------------------------------------------------------------------------
    function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
                                              input logic [31:0] a, input logic [31:0] b);
        logic [31:0] r;
        case (f3)
            3'b000:  r = alt ? a - b : a + b;
            3'b001:  r = a << b[4:0];
            3'b010:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  r = (a < b) ? 32'd1 : 32'd0;
            3'b100:  r = a ^ b;
            3'b101:
            begin
                // SRA keeps the sign, SRL fills with zero
                if (alt)
                    r = $signed(a) >>> b[4:0];
                else
                    r = a >> b[4:0];
            end
            3'b110:  r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    task automatic build_expected(input logic valid, input logic [31:0] w,
                                  input logic [31:0] pc_in, input logic [31:0] a,
                                  input logic [31:0] b, output core_pkg::wb_rec_t exp,
                                  output string name);
        logic [31:0] imm_i;
        logic [31:0] imm_b;
        logic [31:0] imm_u;
        logic [31:0] imm_j;
        logic [31:0] sum;
        logic [31:0] data;
        logic [31:0] target;
        logic        legal;
        logic        writes;
        logic        jump;
        logic        taken;
        // Immediates rebuilt from the raw word
        imm_i  = {{20{w[31]}}, w[31:20]};
        imm_b  = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        imm_u  = {w[31:12], 12'b0};
        imm_j  = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        legal  = 1'b1;
        writes = 1'b0;
        jump   = 1'b0;
        taken  = 1'b0;
        data   = '0;
        target = '0;
        case (w[6:0])
            7'b0110111:
            begin
                name   = "lui";
                writes = 1'b1;
                data   = imm_u;
            end
            7'b0010111:
            begin
                name   = "auipc";
                writes = 1'b1;
                data   = pc_in + imm_u;
            end
            7'b1101111:
            begin
                name   = "jal";
                writes = 1'b1;
                jump   = 1'b1;
                data   = pc_in + 32'd4;
                target = pc_in + imm_j;
            end
            7'b1100111:
            begin
                name   = "jalr";
                legal  = (w[14:12] == 3'b000);
                writes = 1'b1;
                jump   = 1'b1;
                data   = pc_in + 32'd4;
                sum    = a + imm_i;
                target = {sum[31:1], 1'b0};
            end
            7'b1100011:
            begin
                name   = "branch";
                legal  = (w[14:13] != 2'b01);
                target = pc_in + imm_b;
                case (w[14:12])
                    3'b000:  taken = (a == b);
                    3'b001:  taken = (a != b);
                    3'b100:  taken = ($signed(a) < $signed(b));
                    3'b101:  taken = !($signed(a) < $signed(b));
                    3'b110:  taken = (a < b);
                    default: taken = !(a < b);
                endcase
            end
            7'b0010011:
            begin
                name   = "alu_imm";
                writes = 1'b1;
                // Shift immediates carry funct7 in imm[11:5]
                if (w[14:12] == 3'b001)
                    legal = (w[31:25] == 7'h00);
                if (w[14:12] == 3'b101)
                    legal = (w[31:25] == 7'h00) || (w[31:25] == 7'h20);
                data   = alu_model(w[14:12], (w[14:12] == 3'b101) && w[30], a, imm_i);
            end
            7'b0110011:
            begin
                name   = "alu_reg";
                writes = 1'b1;
                legal  = (w[31:25] == 7'h00) ||
                         ((w[31:25] == 7'h20) && (w[14:12] == 3'b000 || w[14:12] == 3'b101));
                data   = alu_model(w[14:12], w[30], a, b);
            end
            default:
            begin
                name  = "unknown_opcode";
                legal = 1'b0;
            end
        endcase
        if (!valid)
            name = "idle_cycle";
        exp                  = '0;
        exp.valid            = valid;
        exp.illegal          = valid && !legal;
        exp.write_index      = w[11:7];
        exp.write_data       = data;
        // Nothing lands in x0
        exp.write_enable     = valid && legal && writes && (w[11:7] != 5'd0);
        exp.redirect         = valid && legal && (jump || taken);
        exp.redirect_address = target;
    endtask

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------
    // Weighted mix of the supported formats plus some raw words
    function automatic logic [31:0] random_word();
        int          kind;
        logic [31:0] r;
        logic [4:0]  rd;
        logic [4:0]  rs1f;
        logic [4:0]  rs2f;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm12;
        logic [31:0] w;
        kind = $urandom_range(0, 99);
        r    = $urandom;
        rd   = ($urandom_range(0, 7) == 0) ? 5'd0 : 5'($urandom);
        rs1f = 5'($urandom);
        rs2f = 5'($urandom);
        f3   = 3'($urandom);
        if (kind < 8)
            w = {r[31:12], rd, core_pkg::OP_LUI};
        else if (kind < 16)
            w = {r[31:12], rd, core_pkg::OP_AUIPC};
        else if (kind < 24)
            w = {r[31:12], rd, core_pkg::OP_JAL};
        else if (kind < 34)
            w = {r[31:20], rs1f, 3'b000, rd, core_pkg::OP_JALR};
        else if (kind < 54)
        begin
            // Skip the two reserved branch codes
            f3 = 3'($urandom_range(0, 5));
            if (f3 >= 3'd2)
                f3 = f3 + 3'd2;
            w = {r[31:25], rs2f, rs1f, f3, r[11:7], core_pkg::OP_BRANCH};
        end
        else if (kind < 74)
        begin
            imm12 = r[31:20];
            if (f3 == 3'b001)
                imm12 = {7'h00, r[24:20]};
            else if (f3 == 3'b101)
                imm12 = {r[0] ? 7'h20 : 7'h00, r[24:20]};
            w = {imm12, rs1f, f3, rd, core_pkg::OP_IMM};
        end
        else if (kind < 94)
        begin
            f7 = ((f3 == 3'b000 || f3 == 3'b101) && r[0]) ? 7'h20 : 7'h00;
            w  = {f7, rs2f, rs1f, f3, rd, core_pkg::OP_REG};
        end
        else
            w = $urandom;
        return w;
    endfunction

    task automatic drive_random();
        core_pkg::wb_rec_t exp;
        string             name;
        in_valid    = ($urandom_range(0, 9) != 0);
        instruction = random_word();
        pc          = $urandom;
        rs1_value   = $urandom;
        // Equal operands now and then so BEQ and BGE see ties
        rs2_value   = ($urandom_range(0, 3) == 0) ? rs1_value : $urandom;
        build_expected(in_valid, instruction, pc, rs1_value, rs2_value, exp, name);
        expected_q.push_back(exp);
        due_q.push_back(cycle + 2);
        name_q.push_back(name);
    endtask

    // ------------------------------------------------------------------------
    // Scoreboard
    // ------------------------------------------------------------------------
    task automatic compare_field(input string test, input string field,
                                 input logic [31:0] expected, input logic [31:0] actual);
        check_count++;
        if (actual !== expected)
        begin
            error_count++;
            $display("[FAIL] %s %s expected %h actual %h", test, field, expected, actual);
        end
    endtask

    // Pops every record due by now and checks it against wb
    task automatic check_due();
        core_pkg::wb_rec_t exp;
        string             name;
        while (expected_q.size() > 0 && due_q[0] <= cycle)
        begin
            exp  = expected_q.pop_front();
            name = name_q.pop_front();
            void'(due_q.pop_front());
            compare_field(name, "valid", exp.valid, wb.valid);
            compare_field(name, "illegal", exp.illegal, wb.illegal);
            compare_field(name, "write_enable", exp.write_enable, wb.write_enable);
            compare_field(name, "redirect", exp.redirect, wb.redirect);
            if (exp.write_enable)
            begin
                compare_field(name, "write_index", exp.write_index, wb.write_index);
                compare_field(name, "write_data", exp.write_data, wb.write_data);
            end
            if (exp.redirect)
                compare_field(name, "redirect_address", exp.redirect_address,
                              wb.redirect_address);
        end
    endtask

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------
    initial
    begin
        void'($urandom(32'h38f98aad));
        CLK           = 1'b0;
        reset         = 1'b1;
        in_valid      = 1'b0;
        instruction   = '0;
        pc            = '0;
        rs1_value     = '0;
        rs2_value     = '0;
        cycle         = 0;
        check_count   = 0;
        error_count   = 0;
        timeout_count = 0;
        repeat (4) @(posedge CLK);
        @(negedge CLK);
        reset = 1'b0;

        // Check the result from two edges back, then drive the next word
        for (int i = 0; i < NUM_INSTR; i++)
        begin
            check_due();
            drive_random();
            @(negedge CLK);
            cycle++;
        end

        // Drain with idle inputs
        in_valid = 1'b0;
        waited   = 0;
        check_due();
        while (expected_q.size() != 0 && waited < DRAIN_LIMIT)
        begin
            @(negedge CLK);
            cycle++;
            waited++;
            check_due();
        end
        if (expected_q.size() != 0)
        begin
            timeout_count++;
            $display("Timeout: %0d expected results never came out of the DUT",
                     expected_q.size());
        end

        $display("Checks %0d, mismatches %0d, timeouts %0d, assertion failures %0d",
                 check_count, error_count, timeout_count, i_dut.i_checks.fail_count);
        if (error_count == 0 && timeout_count == 0 && i_dut.i_checks.fail_count == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

// ==== project.f ====
hdl/core_pkg.sv
hdl/instruction_decoder.sv
hdl/arithmetic_logic_unit.sv
hdl/jump_branch_unit.sv
hdl/writeback_select.sv
hdl/execute_core.sv
dv/execute_core_assertions.sv
dv/execute_core_tb.sv
